// ==== chip_cfg_pkg.sv ====
package chip_cfg_pkg;

  ////////////////////////////////////////
  // Link widths

  localparam int did_width_lp  = 4;
  localparam int word_width_lp = 16;

  typedef logic [did_width_lp-1:0]  did_t;
  typedef logic [word_width_lp-1:0] word_t;

  ////////////////////////////////////////
  // Tag clients

  localparam int tag_num_clients_lp = 3;

  // Two address bits, id 3 has no client behind it
  typedef logic [1:0] client_id_t;

  localparam client_id_t client_core_lp   = 2'd0;
  localparam client_id_t client_host_lp   = 2'd1;
  localparam client_id_t client_router_lp = 2'd2;

  // Configuration held by every client
  typedef struct packed
  {
    logic reset;
    did_t did;
  } tag_payload_t;

  localparam int tag_payload_bits_lp = $bits(tag_payload_t);

  typedef enum logic [1:0]
  {
    tag_idle_e,
    tag_id_e,
    tag_payload_e
  } tag_state_e;

  ////////////////////////////////////////
  // Link flits

  typedef struct packed
  {
    did_t  dst;
    did_t  src;
    word_t data;
  } flit_t;

  localparam int repeat_stages_lp = 3;

endpackage

// ==== tag_master.sv ====
module tag_master
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  logic                       tag_data_i,
  input  logic                       tag_en_i,

  output chip_cfg_pkg::tag_payload_t core_cfg_o,
  output chip_cfg_pkg::tag_payload_t host_cfg_o,
  output chip_cfg_pkg::tag_payload_t router_cfg_o
);

  import chip_cfg_pkg::*;

  typedef logic [$clog2(tag_payload_bits_lp)-1:0] bit_cnt_t;

  logic                              tag_bit;
  tag_state_e                        state_r;
  tag_state_e                        state_n;
  bit_cnt_t                          bit_cnt_r;
  logic                              last_id_bit;
  logic                              last_payload_bit;
  client_id_t                        id_r;
  logic [tag_payload_bits_lp-1:0]    shift_r;
  logic                              write_v_r;
  tag_payload_t [tag_num_clients_lp-1:0] cfg_r;

  // A disabled line reads as idle
  assign tag_bit = tag_en_i & tag_data_i;

  assign last_id_bit      = (state_r == tag_id_e)
                          && (bit_cnt_r == bit_cnt_t'($bits(client_id_t) - 1));
  assign last_payload_bit = (state_r == tag_payload_e)
                          && (bit_cnt_r == bit_cnt_t'(tag_payload_bits_lp - 1));

  ////////////////////////////////////////
  // Packet FSM

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      tag_idle_e:
      begin
        if (tag_bit)
          state_n = tag_id_e;
      end
      tag_id_e:
      begin
        if (last_id_bit)
          state_n = tag_payload_e;
      end
      tag_payload_e:
      begin
        if (last_payload_bit)
          state_n = tag_idle_e;
      end
      default:
        state_n = tag_idle_e;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r   <= tag_idle_e;
      bit_cnt_r <= '0;
      write_v_r <= 1'b0;
    end
    else
    begin
      state_r   <= state_n;
      write_v_r <= last_payload_bit;
      // Count restarts on every phase change
      if (state_n != state_r)
        bit_cnt_r <= '0;
      else if (state_r != tag_idle_e)
        bit_cnt_r <= bit_cnt_r + 1'b1;
    end
  end

  // MSB first for both fields
  always_ff @(posedge clk_i)
  begin
    if (state_r == tag_id_e)
      id_r <= {id_r[0], tag_bit};
    if (state_r == tag_payload_e)
      shift_r <= {shift_r[tag_payload_bits_lp-2:0], tag_bit};
  end

  ////////////////////////////////////////
  // Client registers

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < tag_num_clients_lp; i++)
      begin
        cfg_r[i].reset <= 1'b1;
        cfg_r[i].did   <= '0;
      end
    end
    else if (write_v_r && (id_r < client_id_t'(tag_num_clients_lp)))
    begin
      cfg_r[id_r] <= tag_payload_t'(shift_r);
    end
  end

  assign core_cfg_o   = cfg_r[client_core_lp];
  assign host_cfg_o   = cfg_r[client_host_lp];
  assign router_cfg_o = cfg_r[client_router_lp];

endmodule

// ==== link_endpoint.sv ====
module link_endpoint
(
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  logic                flush_i,
  input  chip_cfg_pkg::did_t  src_did_i,
  input  chip_cfg_pkg::did_t  dst_did_i,

  input  logic                word_v_i,
  input  chip_cfg_pkg::word_t word_i,
  output logic                word_ready_o,

  output logic                flit_v_o,
  output chip_cfg_pkg::flit_t flit_o,
  input  logic                flit_ready_i
);

  import chip_cfg_pkg::*;

  flit_t flit_r;
  logic  flit_v_r;
  logic  word_xfer;
  logic  flit_xfer;

  ////////////////////////////////////////
  // Handshakes

  // Room when empty or when the held flit leaves this cycle
  assign word_ready_o = ~flush_i & (~flit_v_r | flit_ready_i);
  assign flit_v_o     = flit_v_r & ~flush_i;

  assign word_xfer = word_v_i & word_ready_o;
  assign flit_xfer = flit_v_o & flit_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      flit_v_r <= 1'b0;
    else if (flush_i)
      flit_v_r <= 1'b0;
    else if (word_xfer)
      flit_v_r <= 1'b1;
    else if (flit_xfer)
      flit_v_r <= 1'b0;
  end

  // Ids are captured with the word
  always_ff @(posedge clk_i)
  begin
    if (word_xfer)
    begin
      flit_r.dst  <= dst_did_i;
      flit_r.src  <= src_did_i;
      flit_r.data <= word_i;
    end
  end

  assign flit_o = flit_r;

endmodule

// ==== link_repeater.sv ====
module link_repeater
(
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  logic                flush_i,

  input  logic                in_v_i,
  input  chip_cfg_pkg::flit_t in_flit_i,
  output logic                in_ready_o,

  output logic                out_v_o,
  output chip_cfg_pkg::flit_t out_flit_o,
  input  logic                out_ready_i
);

  import chip_cfg_pkg::*;

  flit_t head_r;
  flit_t spare_r;
  logic  head_v_r;
  logic  spare_v_r;
  logic  in_xfer;
  logic  out_xfer;
  logic  head_load;

  ////////////////////////////////////////
  // Handshakes

  // Ready only looks at the spare entry
  assign in_ready_o = ~spare_v_r & ~flush_i;
  assign out_v_o    = head_v_r & ~flush_i;
  assign out_flit_o = head_r;

  assign in_xfer   = in_v_i & in_ready_o;
  assign out_xfer  = out_v_o & out_ready_i;
  assign head_load = ~head_v_r | out_xfer;

  ////////////////////////////////////////
  // Entry control

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      head_v_r  <= 1'b0;
      spare_v_r <= 1'b0;
    end
    else if (flush_i)
    begin
      head_v_r  <= 1'b0;
      spare_v_r <= 1'b0;
    end
    else if (head_load)
    begin
      head_v_r  <= spare_v_r | in_xfer;
      spare_v_r <= 1'b0;
    end
    else if (in_xfer)
    begin
      spare_v_r <= 1'b1;
    end
  end

  // Spare drains into head before any new input
  always_ff @(posedge clk_i)
  begin
    if (head_load)
      head_r <= spare_v_r ? spare_r : in_flit_i;
    else if (in_xfer)
      spare_r <= in_flit_i;
  end

endmodule

// ==== chip_cfg_top.sv ====
module chip_cfg_top
(
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  logic                tag_data_i,
  input  logic                tag_en_i,

  input  logic                word_v_i,
  input  chip_cfg_pkg::word_t word_i,
  output logic                word_ready_o,

  output logic                flit_v_o,
  output chip_cfg_pkg::flit_t flit_o,
  input  logic                flit_ready_i,

  output logic                core_reset_o,
  output chip_cfg_pkg::did_t  core_did_o
);

  import chip_cfg_pkg::*;

  ////////////////////////////////////////
  // Tag master

  tag_payload_t core_cfg_lo;
  tag_payload_t host_cfg_lo;
  tag_payload_t router_cfg_lo;
  logic         link_flush;

  tag_master u_tag_master
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tag_data_i   (tag_data_i),
    .tag_en_i     (tag_en_i),
    .core_cfg_o   (core_cfg_lo),
    .host_cfg_o   (host_cfg_lo),
    .router_cfg_o (router_cfg_lo)
  );

  assign core_reset_o = core_cfg_lo.reset;
  assign core_did_o   = core_cfg_lo.did;

  // Router reset holds the whole link path empty
  assign link_flush = router_cfg_lo.reset;

  ////////////////////////////////////////
  // Link path

  // Hop 0 is the endpoint output, last hop is the block output
  logic  [repeat_stages_lp:0] link_v;
  logic  [repeat_stages_lp:0] link_ready;
  flit_t [repeat_stages_lp:0] link_flit;

  link_endpoint u_link_endpoint
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (link_flush),
    .src_did_i    (core_cfg_lo.did),
    .dst_did_i    (host_cfg_lo.did),
    .word_v_i     (word_v_i),
    .word_i       (word_i),
    .word_ready_o (word_ready_o),
    .flit_v_o     (link_v[0]),
    .flit_o       (link_flit[0]),
    .flit_ready_i (link_ready[0])
  );

  for (genvar i = 0; i < repeat_stages_lp; i++)
  begin : g_repeater
    link_repeater u_link_repeater
    (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .flush_i     (link_flush),
      .in_v_i      (link_v[i]),
      .in_flit_i   (link_flit[i]),
      .in_ready_o  (link_ready[i]),
      .out_v_o     (link_v[i+1]),
      .out_flit_o  (link_flit[i+1]),
      .out_ready_i (link_ready[i+1])
    );
  end

  assign flit_v_o                     = link_v[repeat_stages_lp];
  assign flit_o                       = link_flit[repeat_stages_lp];
  assign link_ready[repeat_stages_lp] = flit_ready_i;

endmodule

// ==== tb_chip_cfg.sv ====
module tb_chip_cfg;

  timeunit 1ns;
  timeprecision 1ps;

  import chip_cfg_pkg::*;

  localparam int pkt_count_lp         = 33;
  localparam int pkt_cycles_lp        = 10;
  localparam int traffic_cycles_lp    = 400;
  localparam int post_flush_cycles_lp = 200;
  localparam int latency_words_lp     = 40;
  localparam int latency_cycles_lp    = 100;
  localparam int drain_cycles_lp      = 64;
  localparam int planned_cycles_lp    = 16 + pkt_count_lp * pkt_cycles_lp + traffic_cycles_lp
                                      + post_flush_cycles_lp + latency_cycles_lp + 22
                                      + 3 * (drain_cycles_lp + 8);
  localparam int watchdog_ns_lp       = planned_cycles_lp * 2 * 20;

  logic         clk_i;
  logic         rst_n_i;
  logic         tag_data_i;
  logic         tag_en_i;
  logic         word_v_i;
  word_t        word_i;
  logic         word_ready_o;
  logic         flit_v_o;
  flit_t        flit_o;
  logic         flit_ready_i;
  logic         core_reset_o;
  did_t         core_did_o;

  // Reference model state
  tag_payload_t model_cfg [tag_num_clients_lp];
  flit_t        exp_q[$];
  int           acc_q[$];
  flit_t        exp_flit;
  flit_t        stamp;
  int           acc_cyc;
  int           latency_base;
  int           cycle;
  int           words_in;
  int           flits_out;
  int           errors;
  logic         word_taken;
  logic         check_latency;
  string        test_name;

  chip_cfg_top u_chip_cfg_top
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tag_data_i   (tag_data_i),
    .tag_en_i     (tag_en_i),
    .word_v_i     (word_v_i),
    .word_i       (word_i),
    .word_ready_o (word_ready_o),
    .flit_v_o     (flit_v_o),
    .flit_o       (flit_o),
    .flit_ready_i (flit_ready_i),
    .core_reset_o (core_reset_o),
    .core_did_o   (core_did_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial
  begin
    #(watchdog_ns_lp);
    $display("Watchdog expired before the tests finished");
    $display("** FAIL **");
    $finish;
  end

  always @(posedge clk_i)
    cycle++;

  ////////////////////////////////////////
  // Monitor, sampled mid-cycle

  always @(negedge clk_i)
  begin
    word_taken = word_v_i && word_ready_o;
    if (flit_v_o && flit_ready_i)
    begin
      if (exp_q.size() == 0)
      begin
        $display("%s: flit %h left the link with no word outstanding", test_name, flit_o);
        errors++;
      end
      else
      begin
        exp_flit = exp_q.pop_front();
        acc_cyc  = acc_q.pop_front();
        flits_out++;
        if (flit_o !== exp_flit)
          value_error("flit", 32'(exp_flit), 32'(flit_o));
        if (check_latency && (cycle + 1 - acc_cyc != 4))
          value_error("latency", 32'd4, 32'(cycle + 1 - acc_cyc));
      end
    end
    // Ids in force at the acceptance edge
    if (word_taken)
    begin
      stamp.dst  = model_cfg[client_host_lp].did;
      stamp.src  = model_cfg[client_core_lp].did;
      stamp.data = word_i;
      exp_q.push_back(stamp);
      acc_q.push_back(cycle + 1);
      words_in++;
    end
  end

  task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
    begin
      $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_core();
    begin
      if ({core_reset_o, core_did_o} !== model_cfg[client_core_lp])
        value_error("core cfg", 32'(model_cfg[client_core_lp]), 32'({core_reset_o, core_did_o}));
    end
  endtask

  // Start bit, client id and payload, all MSB first
  task automatic send_packet(input logic en, input client_id_t id, input tag_payload_t pl);
    logic [7:0] bits;
    begin
      bits = {1'b1, id, pl};
      for (int i = 7; i >= 0; i--)
      begin
        @(posedge clk_i);
        #2;
        tag_en_i   = en;
        tag_data_i = bits[i];
      end
      @(posedge clk_i);
      #2;
      tag_en_i   = 1'b0;
      tag_data_i = 1'b0;
      // Edge N has sampled the last bit, register not yet written
      check_core();
      @(posedge clk_i);
      #2;
      if (en && (id < 2'd3))
        model_cfg[id] = pl;
      if (model_cfg[client_router_lp].reset)
      begin
        exp_q.delete();
        acc_q.delete();
      end
    end
  endtask

  function automatic tag_payload_t random_payload(input logic reset);
    tag_payload_t pl;
    begin
      pl.reset = reset;
      pl.did   = did_t'($urandom);
      return pl;
    end
  endfunction

  // A word is held on the port until the endpoint takes it
  task automatic traffic_cycle(input int valid_pct, input int ready_pct);
    begin
      @(posedge clk_i);
      #2;
      if (word_taken || !word_v_i)
      begin
        word_i   = word_t'($urandom);
        word_v_i = ($urandom_range(99) < valid_pct);
      end
      flit_ready_i = ($urandom_range(99) < ready_pct);
    end
  endtask

  task automatic drain_link();
    int waited;
    begin
      @(posedge clk_i);
      #2;
      word_v_i     = 1'b0;
      flit_ready_i = 1'b1;
      waited       = 0;
      while ((exp_q.size() != 0) && (waited < drain_cycles_lp))
      begin
        @(posedge clk_i);
        #2;
        waited++;
      end
      if (exp_q.size() != 0)
      begin
        $display("%s: link did not drain, %0d flits still missing", test_name, exp_q.size());
        errors++;
      end
      // Stray flits would show up here
      repeat (8) @(posedge clk_i);
      #2;
    end
  endtask

  ////////////////////////////////////////
  // Test sequence

  initial
  begin
    void'($urandom(32'h131f_b2e1));
    rst_n_i       = 1'b0;
    tag_data_i    = 1'b0;
    tag_en_i      = 1'b0;
    word_v_i      = 1'b0;
    word_i        = '0;
    flit_ready_i  = 1'b0;
    cycle         = 0;
    words_in      = 0;
    flits_out     = 0;
    errors        = 0;
    word_taken    = 1'b0;
    check_latency = 1'b0;
    for (int i = 0; i < tag_num_clients_lp; i++)
    begin
      model_cfg[i].reset = 1'b1;
      model_cfg[i].did   = '0;
    end

    test_name = "reset";
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #2;
    check_core();
    if (word_ready_o !== 1'b0)
      value_error("word_ready_o", 32'd0, 32'(word_ready_o));
    if (flit_v_o !== 1'b0)
      value_error("flit_v_o", 32'd0, 32'(flit_v_o));

    test_name = "core_tag";
    repeat (20)
    begin
      send_packet(1'b1, client_core_lp, random_payload(1'($urandom)));
      check_core();
    end

    test_name = "ignored_tag";
    repeat (4)
    begin
      send_packet(1'b0, client_core_lp, random_payload(1'($urandom)));
      check_core();
    end
    repeat (2)
    begin
      send_packet(1'b1, 2'd3, random_payload(1'($urandom)));
      check_core();
      send_packet(1'b1, client_core_lp, random_payload(1'($urandom)));
      check_core();
    end

    test_name = "traffic";
    send_packet(1'b1, client_host_lp, random_payload(1'b0));
    send_packet(1'b1, client_core_lp, random_payload(1'b0));
    send_packet(1'b1, client_router_lp, random_payload(1'b0));
    repeat (traffic_cycles_lp) traffic_cycle(70, 50);
    drain_link();

    test_name     = "latency";
    check_latency = 1'b1;
    latency_base  = words_in;
    for (int n = 0; (n < latency_cycles_lp) && (words_in - latency_base < latency_words_lp); n++)
      traffic_cycle(60, 100);
    if (words_in - latency_base < latency_words_lp)
    begin
      $display("%s: only %0d words were accepted in time", test_name, words_in - latency_base);
      errors++;
    end
    drain_link();
    check_latency = 1'b0;

    test_name = "flush";
    // Pile flits up in every node before the flush
    repeat (12) traffic_cycle(100, 0);
    // Endpoint plus two entries per repeater
    if (word_ready_o !== 1'b0)
      value_error("word_ready_o", 32'd0, 32'(word_ready_o));
    if (exp_q.size() != 1 + 2 * repeat_stages_lp)
      value_error("pile depth", 32'(1 + 2 * repeat_stages_lp), 32'(exp_q.size()));
    send_packet(1'b1, client_router_lp, random_payload(1'b1));
    repeat (10)
    begin
      traffic_cycle(100, 100);
      if (word_ready_o !== 1'b0)
        value_error("word_ready_o", 32'd0, 32'(word_ready_o));
      if (flit_v_o !== 1'b0)
        value_error("flit_v_o", 32'd0, 32'(flit_v_o));
    end
    send_packet(1'b1, client_router_lp, random_payload(1'b0));
    repeat (post_flush_cycles_lp) traffic_cycle(70, 60);
    drain_link();

    $display("Words accepted %0d, flits checked %0d, errors %0d", words_in, flits_out, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== list.f ====
chip_cfg_pkg.sv
tag_master.sv
link_endpoint.sv
link_repeater.sv
chip_cfg_top.sv
tb_chip_cfg.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f list.f --top-module tb_chip_cfg -o sim_chip_cfg || exit 1
out=$(./obj_dir/sim_chip_cfg)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '** PASS **' && exit 0 || exit 1
